//--- common/bus_pkg.sv
// Bus widths, vector types and frame field lengths, imported by the datapath and top modules
package bus_pkg;

    //////////////////////////////////////////////////
    // Field widths

    localparam int ID_BITS   = 3;
    localparam int ADDR_BITS = 15;
    localparam int DATA_BITS = 8;

    // Start bit + ID + address + rw
    localparam int HDR_BITS  = 1 + ID_BITS + ADDR_BITS + 1;

    localparam int CNT_W     = 5;   // Covers HDR_BITS

    // Level of the rw bit that asks for a read
    localparam logic RW_READ = 1'b1;

    //////////////////////////////////////////////////
    // Vector types

    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [ID_BITS-1:0]   slave_id_t;
    typedef logic [HDR_BITS-1:0]  hdr_t;    // Whole header word, MSB first on the line
    typedef logic [CNT_W-1:0]     cnt_t;

endpackage

//--- common/ctrl_pkg.sv
// State encodings for the master, slave and arbiter FSMs, imported where a state register lives
package ctrl_pkg;

    // Master phases
    typedef enum logic [2:0] {
        MST_IDLE,
        MST_REQUEST,    // Waiting for grant
        MST_HEADER,
        MST_TURN,       // Read turnaround
        MST_DATA,
        MST_DONE
    } master_state_e;

    // Slave phases
    typedef enum logic [2:0] {
        SLV_IDLE,
        SLV_HEADER,
        SLV_TURN,
        SLV_DATA,
        SLV_SKIP        // Following a frame for another ID
    } slave_state_e;

    // Arbiter phases
    typedef enum logic [1:0] {
        ARB_FREE,
        ARB_OWN0,
        ARB_OWN1
    } arb_state_e;

endpackage

//--- common/master_link_if.sv
// Link between one bus master and the arbiter, one instance per master in the top level
interface master_link_if;

    logic request;  // Held until grant is seen
    logic grant;    // Held while active is high
    logic drive;    // Bit the master puts on the wired-AND line, 1 when released
    logic active;   // Frame in progress
    logic line;     // Resolved bus line

    //////////////////////////////////////////////////
    // Master side

    modport node (
        output request,
        output drive,
        output active,
        input  grant,
        input  line
    );

    //////////////////////////////////////////////////
    // Arbiter side

    modport hub (
        input  request,
        input  drive,
        input  active,
        output grant,
        output line
    );

endinterface

//--- master/master_shifter.sv
// Frame shift register for a master, sends fields MSB first and collects read data
module master_shifter
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  load,         // Wins over shift
    input  hdr_t  load_value,   // Field left aligned
    input  cnt_t  load_len,     // Bits in the field
    input  logic  shift,
    input  logic  serial_in,
    output logic  serial_out,
    output logic  last,
    output data_t parallel_out
);

    hdr_t sreg;
    cnt_t cnt;  // Bits left after the current one

    //////////////////////////////////////////////////
    // Bit counter

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= load_len - 1'b1;
        end else if (shift && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Data register
    always_ff @(posedge clk) begin
        if (load) begin
            sreg <= load_value;
        end else if (shift) begin
            sreg <= {sreg[HDR_BITS-2:0], serial_in};  // Line enters at the bottom
        end
    end

    assign serial_out   = sreg[HDR_BITS-1];
    assign last         = (cnt == '0);
    assign parallel_out = sreg[DATA_BITS-1:0];

endmodule

//--- master/master_ctrl.sv
// Bus master controller, turns a parallel command into one serial frame over the shared line
module master_ctrl
    import bus_pkg::*;
    import ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        execute,    // One cycle strobe, ignored while busy
    input  logic        rw,         // RW_READ for a read
    input  slave_id_t   slave_id,
    input  addr_t       address,
    input  data_t       din,
    output data_t       dout,
    output logic        dvalid,
    output logic        busy,
    master_link_if.node link
);

    master_state_e state;

    // Latched command
    logic      rw_q;
    slave_id_t id_q;
    addr_t     addr_q;
    data_t     din_q;
    logic      is_read;

    // Shifter controls
    logic  sh_load;
    hdr_t  sh_value;
    cnt_t  sh_len;
    logic  sh_shift;
    logic  sh_out;
    logic  sh_last;
    data_t sh_data;

    assign is_read = (rw_q == RW_READ);

    //////////////////////////////////////////////////
    // FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= MST_IDLE;
            dvalid <= 1'b0;
        end else begin
            dvalid <= (state == MST_DONE) && is_read;   // Lines up with busy falling
            case (state)
                MST_IDLE:    if (execute) state <= MST_REQUEST;
                MST_REQUEST: if (link.grant) state <= MST_HEADER;
                MST_HEADER:  if (sh_last) state <= is_read ? MST_TURN : MST_DATA;
                MST_TURN:    state <= MST_DATA;
                MST_DATA:    if (sh_last) state <= MST_DONE;
                MST_DONE:    state <= MST_IDLE;
                default:     state <= MST_IDLE;
            endcase
        end
    end

    // Command capture and read result
    always_ff @(posedge clk) begin
        if (state == MST_IDLE && execute) begin
            rw_q   <= rw;
            id_q   <= slave_id;
            addr_q <= address;
            din_q  <= din;
        end
        if (state == MST_DONE && is_read) dout <= sh_data;
    end

    //////////////////////////////////////////////////
    // Shifter loading

    always_comb begin
        sh_load  = 1'b0;
        sh_value = '1;
        sh_len   = cnt_t'(DATA_BITS);
        if (state == MST_REQUEST && link.grant) begin
            sh_load  = 1'b1;
            sh_value = {1'b0, id_q, addr_q, rw_q};  // Start bit leads
            sh_len   = cnt_t'(HDR_BITS);
        end else if (state == MST_HEADER && sh_last && !is_read) begin
            sh_load  = 1'b1;
            sh_value = {din_q, {(HDR_BITS-DATA_BITS){1'b1}}};
        end else if (state == MST_TURN) begin
            sh_load  = 1'b1;                        // Empty byte to capture into
        end
    end

    assign sh_shift = (state == MST_HEADER) || (state == MST_DATA);

    master_shifter i_shifter (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (sh_load),
        .load_value   (sh_value),
        .load_len     (sh_len),
        .shift        (sh_shift),
        .serial_in    (link.line),
        .serial_out   (sh_out),
        .last         (sh_last),
        .parallel_out (sh_data)
    );

    assign link.request = (state == MST_REQUEST);
    assign link.active  = (state == MST_HEADER) || (state == MST_TURN) || (state == MST_DATA);
    assign link.drive   = (state == MST_HEADER || (state == MST_DATA && !is_read)) ? sh_out : 1'b1;
    assign busy         = (state != MST_IDLE);

    // A master may only pull the line low while it owns the bus
    drive_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !link.drive |-> link.grant)
        else $error("master drove the line without grant");

endmodule

//--- slave/slave_mem.sv
// Slave register memory, written at the end of a write frame and read combinationally
module slave_mem
    import bus_pkg::*;
#(
    parameter int MEM_ADDR_W = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  we,
    input  logic [MEM_ADDR_W-1:0] waddr,
    input  logic [MEM_ADDR_W-1:0] raddr,
    input  data_t                 wdata,
    output data_t                 rdata
);

    localparam int DEPTH = 1 << MEM_ADDR_W;

    data_t mem [DEPTH];

    // Every entry reads 0 after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];

endmodule

//--- slave/slave_port.sv
// Slave frame receiver that decodes the header and serves writes and reads from its memory
module slave_port
    import bus_pkg::*;
    import ctrl_pkg::*;
#(
    parameter slave_id_t SELF_ID    = 3'b101,
    parameter int        MEM_ADDR_W = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic line,
    output logic slave_drive    // 1 when not sending
);

    slave_state_e state;
    cnt_t         cnt;
    logic         rw_q;         // rw bit of the frame in progress
    logic         we_q;

    logic [HDR_BITS-3:0]   hdr_q;   // Header bits after the start bit except the newest
    logic [HDR_BITS-2:0]   hdr_full;
    slave_id_t             hdr_id;
    addr_t                 hdr_addr;
    logic                  hdr_rw;
    logic [MEM_ADDR_W-1:0] addr_q;
    data_t                 sdata;
    data_t                 mem_rdata;

    // Newest bit comes straight from the line
    assign hdr_full = {hdr_q, line};
    assign hdr_id   = hdr_full[HDR_BITS-2 -: ID_BITS];
    assign hdr_addr = hdr_full[ADDR_BITS:1];
    assign hdr_rw   = hdr_full[0];

    //////////////////////////////////////////////////
    // FSM

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SLV_IDLE;
            cnt   <= '0;
            rw_q  <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            we_q <= 1'b0;
            case (state)
                SLV_IDLE: begin
                    if (!line) begin  // Start bit
                        state <= SLV_HEADER;
                        cnt   <= cnt_t'(HDR_BITS - 2);
                    end
                end
                SLV_HEADER: begin
                    if (cnt == '0) begin
                        rw_q <= hdr_rw;
                        if (hdr_id == SELF_ID) begin
                            state <= (hdr_rw == RW_READ) ? SLV_TURN : SLV_DATA;
                            cnt   <= cnt_t'(DATA_BITS - 1);
                        end else begin
                            // Reads carry one extra turnaround cycle
                            state <= SLV_SKIP;
                            cnt   <= (hdr_rw == RW_READ) ? cnt_t'(DATA_BITS) : cnt_t'(DATA_BITS - 1);
                        end
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                SLV_TURN: state <= SLV_DATA;
                SLV_DATA, SLV_SKIP: begin
                    if (cnt == '0) begin
                        state <= SLV_IDLE;
                        we_q  <= (state == SLV_DATA) && (rw_q != RW_READ);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= SLV_IDLE;
            endcase
        end
    end

    // Header and data shifting
    always_ff @(posedge clk) begin
        if (state == SLV_HEADER) begin
            hdr_q <= hdr_full[HDR_BITS-3:0];
            if (cnt == '0) addr_q <= hdr_addr[MEM_ADDR_W-1:0];
        end
        if (state == SLV_TURN) sdata <= mem_rdata;
        else if (state == SLV_DATA) sdata <= {sdata[DATA_BITS-2:0], line};
    end

    slave_mem #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) i_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (we_q),
        .waddr (addr_q),
        .raddr (addr_q),
        .wdata (sdata),
        .rdata (mem_rdata)
    );

    assign slave_drive = (state == SLV_DATA && rw_q == RW_READ) ? sdata[DATA_BITS-1] : 1'b1;

    // While the slave answers a read nobody else moves the line
    read_reply_owns_line: assert property (@(posedge clk) disable iff (!rst_n)
        (state == SLV_DATA) && (rw_q == RW_READ) |-> (line == slave_drive))
        else $error("line differs from the slave reply bit during a read");

endmodule

//--- hdl/bus_arbiter.sv
// Round-robin arbiter that grants the bus to one of two masters and forms the wired-AND line
module bus_arbiter
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    master_link_if.hub m0,
    master_link_if.hub m1,
    input  logic       slave_drive
);

    arb_state_e state;
    logic       last_owner;     // Master that held the bus most recently
    logic       bus_line;

    //////////////////////////////////////////////////
    // Ownership

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ARB_FREE;
            last_owner <= 1'b1;     // Master 0 wins the first tie
        end else begin
            case (state)
                ARB_FREE: begin
                    if (m0.request && (!m1.request || last_owner)) begin
                        state <= ARB_OWN0;
                    end else if (m1.request) begin
                        state <= ARB_OWN1;
                    end
                end
                ARB_OWN0: begin
                    // Request still high in the cycle grant appears
                    if (!m0.request && !m0.active) begin
                        state      <= ARB_FREE;
                        last_owner <= 1'b0;
                    end
                end
                ARB_OWN1: begin
                    if (!m1.request && !m1.active) begin
                        state      <= ARB_FREE;
                        last_owner <= 1'b1;
                    end
                end
                default: state <= ARB_FREE;
            endcase
        end
    end

    assign m0.grant = (state == ARB_OWN0);
    assign m1.grant = (state == ARB_OWN1);

    //////////////////////////////////////////////////
    // Wired-AND line that idles high

    assign bus_line = (m0.grant ? m0.drive : 1'b1)
                    & (m1.grant ? m1.drive : 1'b1)
                    & slave_drive;

    assign m0.line = bus_line;
    assign m1.line = bus_line;

    // Only one master may be inside a frame
    one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !(m0.active && m1.active))
        else $error("both masters are in a frame at once");

endmodule

//--- hdl/serial_bus_top.sv
// Serial bus top level with two masters, the arbiter and one slave, driven by the testbench
module serial_bus_top
    import bus_pkg::*;
#(
    parameter slave_id_t SELF_ID    = 3'b101,
    parameter int        MEM_ADDR_W = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    // Master 0 command side
    input  logic      m0_execute,
    input  logic      m0_rw,
    input  slave_id_t m0_slave_id,
    input  addr_t     m0_address,
    input  data_t     m0_din,
    output data_t     m0_dout,
    output logic      m0_dvalid,
    output logic      m0_busy,
    // Master 1 command side
    input  logic      m1_execute,
    input  logic      m1_rw,
    input  slave_id_t m1_slave_id,
    input  addr_t     m1_address,
    input  data_t     m1_din,
    output data_t     m1_dout,
    output logic      m1_dvalid,
    output logic      m1_busy
);

    master_link_if link0 ();
    master_link_if link1 ();

    logic slave_drive;

    master_ctrl i_master0 (
        .clk (clk), .rst_n (rst_n),
        .execute (m0_execute), .rw (m0_rw), .slave_id (m0_slave_id),
        .address (m0_address), .din (m0_din), .dout (m0_dout),
        .dvalid (m0_dvalid), .busy (m0_busy), .link (link0.node)
    );

    master_ctrl i_master1 (
        .clk (clk), .rst_n (rst_n),
        .execute (m1_execute), .rw (m1_rw), .slave_id (m1_slave_id),
        .address (m1_address), .din (m1_din), .dout (m1_dout),
        .dvalid (m1_dvalid), .busy (m1_busy), .link (link1.node)
    );

    bus_arbiter i_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .m0          (link0.hub),
        .m1          (link1.hub),
        .slave_drive (slave_drive)
    );

    // Both links carry the same resolved line
    slave_port #(
        .SELF_ID    (SELF_ID),
        .MEM_ADDR_W (MEM_ADDR_W)
    ) i_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .line        (link0.line),
        .slave_drive (slave_drive)
    );

endmodule

//--- sim/tb_serial_bus_table.svh
// Command table for the serial bus testbench, included into the testbench module body
// Columns: name, masters (bit 0 m0, bit 1 m1), rw of the lone master or of m0 on a dual row
// (m1 then takes the other op), slave ID, address, data, random data flag, expected read byte

localparam int NUM_ROWS = 21;

task automatic fill_table();
    // Master 0 wins the tie after reset and reads the cleared entry
    add_row("dual read first, reset value", 2'b11, RD, 3'b101, 15'h0003, 8'h77, 1'b0, 9'h000);
    add_row("read back dual write",         2'b10, RD, 3'b101, 15'h7FF3, 8'h00, 1'b0, 9'h077);

    //////////////////////////////////////////////////
    // Write by one master, read by the other
    add_row("m0 write random",              2'b01, WR, 3'b101, 15'h0006, 8'h00, 1'b1, FROM_MODEL);
    add_row("m1 read same low bits",        2'b10, RD, 3'b101, 15'h1236, 8'h00, 1'b0, FROM_MODEL);
    add_row("m1 write fixed",               2'b10, WR, 3'b101, 15'h000A, 8'h5A, 1'b0, FROM_MODEL);
    add_row("m0 read fixed",                2'b01, RD, 3'b101, 15'h000A, 8'h00, 1'b0, 9'h05A);

    //////////////////////////////////////////////////
    // Absent IDs
    add_row("read absent ID",               2'b01, RD, 3'b010, 15'h000A, 8'h00, 1'b0, 9'h0FF);
    add_row("write absent ID",              2'b01, WR, 3'b011, 15'h000A, 8'h11, 1'b0, FROM_MODEL);
    add_row("entry unchanged",              2'b10, RD, 3'b101, 15'h000A, 8'h00, 1'b0, 9'h05A);

    //////////////////////////////////////////////////
    // Aliasing above bit 3, last write wins
    add_row("alias write 1",                2'b01, WR, 3'b101, 15'h0009, 8'h21, 1'b0, FROM_MODEL);
    add_row("alias write 2",                2'b10, WR, 3'b101, 15'h0019, 8'h42, 1'b0, FROM_MODEL);
    add_row("alias write 3",                2'b01, WR, 3'b101, 15'h4A09, 8'h63, 1'b0, FROM_MODEL);
    add_row("alias read m1",                2'b10, RD, 3'b101, 15'h0009, 8'h00, 1'b0, 9'h063);
    add_row("alias read m0",                2'b01, RD, 3'b101, 15'h7FF9, 8'h00, 1'b0, 9'h063);

    //////////////////////////////////////////////////
    // Contention, m0 owned last so m1 reads before the write
    add_row("dual m1 read first",           2'b11, WR, 3'b101, 15'h000C, 8'hC3, 1'b0, 9'h000);
    add_row("read after dual write",        2'b10, RD, 3'b101, 15'h000C, 8'h00, 1'b0, 9'h0C3);
    add_row("dual m0 read first",           2'b11, RD, 3'b101, 15'h000C, 8'h3C, 1'b0, 9'h0C3);
    add_row("dual random write",            2'b11, WR, 3'b101, 15'h0002, 8'h00, 1'b1, FROM_MODEL);
    add_row("read dual write",              2'b01, RD, 3'b101, 15'h000C, 8'h00, 1'b0, 9'h03C);
    add_row("read absent ID again",         2'b10, RD, 3'b111, 15'h0002, 8'h00, 1'b0, 9'h0FF);
    add_row("read random entry",            2'b01, RD, 3'b101, 15'h0002, 8'h00, 1'b0, FROM_MODEL);
endtask

//--- sim/tb_serial_bus.sv
// Testbench for the serial bus top level, runs the included command table against a memory model
module tb_serial_bus
    import bus_pkg::*;
;

    localparam int        CLK_PERIOD   = 20;
    localparam int        DRIVE_DELAY  = 2;
    localparam int        RESET_CYCLES = 5;
    localparam int        MAX_ROWS     = 32;
    localparam slave_id_t SELF_ID      = 3'b101;
    localparam int        MEM_ADDR_W   = 4;

    localparam logic       RD         = RW_READ;
    localparam logic       WR         = ~RW_READ;
    localparam logic [8:0] FROM_MODEL = 9'h100;    // Expected byte comes from the model

    logic      clk;
    logic      rst_n;
    logic      m0_execute, m0_rw, m0_dvalid, m0_busy;
    slave_id_t m0_slave_id;
    addr_t     m0_address;
    data_t     m0_din, m0_dout;
    logic      m1_execute, m1_rw, m1_dvalid, m1_busy;
    slave_id_t m1_slave_id;
    addr_t     m1_address;
    data_t     m1_din, m1_dout;

    // Table storage
    string      row_name [MAX_ROWS];
    logic [1:0] row_mask [MAX_ROWS];
    logic       row_rw   [MAX_ROWS];
    slave_id_t  row_id   [MAX_ROWS];
    addr_t      row_addr [MAX_ROWS];
    data_t      row_data [MAX_ROWS];
    logic       row_rnd  [MAX_ROWS];
    logic [8:0] row_exp  [MAX_ROWS];
    int         row_count;

    // Reference model state
    data_t  ref_mem [16];
    logic   m1_owned_last;  // Decides the next tie
    integer seed;
    int     errors;
    int     checks;
    int     current_row;

    serial_bus_top #(
        .SELF_ID    (SELF_ID),
        .MEM_ADDR_W (MEM_ADDR_W)
    ) i_serial_bus_top (
        .clk (clk), .rst_n (rst_n),
        .m0_execute (m0_execute), .m0_rw (m0_rw), .m0_slave_id (m0_slave_id),
        .m0_address (m0_address), .m0_din (m0_din), .m0_dout (m0_dout),
        .m0_dvalid (m0_dvalid), .m0_busy (m0_busy),
        .m1_execute (m1_execute), .m1_rw (m1_rw), .m1_slave_id (m1_slave_id),
        .m1_address (m1_address), .m1_din (m1_din), .m1_dout (m1_dout),
        .m1_dvalid (m1_dvalid), .m1_busy (m1_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(input string name, input logic [1:0] mask, input logic rw,
                           input slave_id_t id, input addr_t addr, input data_t data,
                           input logic rnd, input logic [8:0] exp_byte);
        if (row_count < MAX_ROWS) begin
            row_name[row_count] = name;
            row_mask[row_count] = mask;
            row_rw[row_count]   = rw;
            row_id[row_count]   = id;
            row_addr[row_count] = addr;
            row_data[row_count] = data;
            row_rnd[row_count]  = rnd;
            row_exp[row_count]  = exp_byte;
        end
        row_count++;
    endtask

    `include "tb_serial_bus_table.svh"

    //////////////////////////////////////////////////
    // Checking and reference model

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR t=%0t %s: got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Absent IDs read all ones, memory is indexed by the low four address bits
    task automatic predict_op(input logic rw, input slave_id_t id, input addr_t addr,
                              input data_t data, output data_t rd_byte);
        rd_byte = 8'hFF;
        if (id == SELF_ID) begin
            if (rw == RD) rd_byte = ref_mem[addr[3:0]];
            else ref_mem[addr[3:0]] = data;
        end
    endtask

    //////////////////////////////////////////////////
    // One table row

    task automatic run_row(input int r);
        logic [31:0] rand_word;
        data_t       wdata;
        logic        rw0;
        logic        rw1;
        data_t       exp0;
        data_t       exp1;
        logic        m0_first;
        logic        done0;
        logic        done1;
        int          errs_before;

        current_row = r;
        errs_before = errors;
        wdata = row_data[r];
        if (row_rnd[r]) begin
            rand_word = $random(seed);
            wdata = rand_word[7:0];
        end
        rw0 = row_rw[r];
        rw1 = (row_mask[r] == 2'b11) ? ~row_rw[r] : row_rw[r];

        // Tie goes to the master that did not own the bus last
        m0_first = (row_mask[r] == 2'b11) ? m1_owned_last : row_mask[r][0];
        if (m0_first) begin
            if (row_mask[r][0]) predict_op(rw0, row_id[r], row_addr[r], wdata, exp0);
            if (row_mask[r][1]) predict_op(rw1, row_id[r], row_addr[r], wdata, exp1);
            m1_owned_last = row_mask[r][1];
        end else begin
            if (row_mask[r][1]) predict_op(rw1, row_id[r], row_addr[r], wdata, exp1);
            if (row_mask[r][0]) predict_op(rw0, row_id[r], row_addr[r], wdata, exp0);
            m1_owned_last = !row_mask[r][0];
        end
        if (!row_exp[r][8]) begin
            exp0 = row_exp[r][7:0];
            exp1 = row_exp[r][7:0];
        end

        @(posedge clk);
        #DRIVE_DELAY;
        m0_execute  = row_mask[r][0];
        m0_rw       = rw0;
        m0_slave_id = row_id[r];
        m0_address  = row_addr[r];
        m0_din      = wdata;
        m1_execute  = row_mask[r][1];
        m1_rw       = rw1;
        m1_slave_id = row_id[r];
        m1_address  = row_addr[r];
        m1_din      = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        m0_execute = 1'b0;
        m1_execute = 1'b0;

        // Sample mid cycle, dvalid belongs to the cycle busy falls
        done0 = !row_mask[r][0];
        done1 = !row_mask[r][1];
        while (!(done0 && done1)) begin
            @(negedge clk);
            if (!done0 && !m0_busy) begin
                done0 = 1'b1;
                check_value($sformatf("row %0d m0 dvalid", r), m0_dvalid, rw0 == RD);
                if (rw0 == RD) check_value($sformatf("row %0d m0 dout", r), m0_dout, exp0);
            end
            if (!done1 && !m1_busy) begin
                done1 = 1'b1;
                check_value($sformatf("row %0d m1 dvalid", r), m1_dvalid, rw1 == RD);
                if (rw1 == RD) check_value($sformatf("row %0d m1 dout", r), m1_dout, exp1);
            end
        end
        $display("row %2d %-30s %s", r, row_name[r], (errors == errs_before) ? "ok" : "mismatch");
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        m0_execute  = 1'b0;
        m0_rw       = 1'b0;
        m0_slave_id = '0;
        m0_address  = '0;
        m0_din      = '0;
        m1_execute  = 1'b0;
        m1_rw       = 1'b0;
        m1_slave_id = '0;
        m1_address  = '0;
        m1_din      = '0;
        rst_n       = 1'b0;
        seed        = 92;
        errors      = 0;
        checks      = 0;
        row_count   = 0;
        current_row = -1;
        m1_owned_last = 1'b1;   // Master 0 wins the first tie
        for (int i = 0; i < 16; i++) begin
            ref_mem[i] = '0;
        end
        fill_table();
        if (row_count != NUM_ROWS) begin
            errors++;
            $display("Table has %0d rows where %0d were declared", row_count, NUM_ROWS);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog, 64 cycles per row plus reset
    initial begin : watchdog
        #((NUM_ROWS * 64 + RESET_CYCLES + 4) * CLK_PERIOD);
        $display("Timeout: row %0d did not finish in time", current_row);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+sim
common/bus_pkg.sv
common/ctrl_pkg.sv
common/master_link_if.sv
master/master_shifter.sv
master/master_ctrl.sv
slave/slave_mem.sv
slave/slave_port.sv
hdl/bus_arbiter.sv
hdl/serial_bus_top.sv
sim/tb_serial_bus.sv
